/* src/helios_pkg.sv */
package helios_pkg;

    localparam int XLEN    = 32;
    localparam int RRF_NUM = 8;
    localparam int RRF_SEL = $clog2(RRF_NUM);

    typedef logic [XLEN-1:0]    addr_t;
    typedef logic [XLEN-1:0]    insn_t;
    typedef logic [XLEN-1:0]    data_t;
    typedef logic [4:0]         reg_sel_t;
    typedef logic [RRF_SEL-1:0] rrf_tag_t;
    typedef logic [3:0]         alu_op_t;

    localparam addr_t ENTRY_POINT = 32'h0000_0000;

    // major opcodes handled by the core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLL  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_SLT  = 4'd8;
    localparam alu_op_t ALU_SLTU = 4'd9;

    // ID -> DP
    typedef struct packed {
        logic     valid;
        reg_sel_t rd;
        reg_sel_t rs1;
        reg_sel_t rs2;
        data_t    imm;
        logic     use_imm;
        logic     wr_reg;
        alu_op_t  alu_op;
        logic     illegal;
    } decoded_insn_t;

    // DP -> EX
    typedef struct packed {
        logic     valid;
        rrf_tag_t tag;
        data_t    op1;
        data_t    op2;
        alu_op_t  alu_op;
    } dispatch_t;

    typedef struct packed {
        logic     valid;
        rrf_tag_t tag;
        data_t    data;
    } exe_result_t;

    typedef struct packed {
        logic     valid;
        rrf_tag_t tag;
        reg_sel_t rd;
        logic     wr_reg;
        data_t    data;
    } commit_t;

endpackage

/* src/core_ctrl.sv */
`timescale 1ns/1ps

module core_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  helios_pkg::decoded_insn_t dec_i,
    input  logic                      rob_full_i,
    input  logic                      rob_empty_i,
    output logic                      fetch_en_o,
    output logic                      dispatch_en_o,
    output logic                      halted_o
);
    import helios_pkg::*;

    typedef enum logic [1:0] {
        RUN,
        DRAIN,
        HALTED
    } ctrl_state_e;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        stop;
    logic        run;

    // first undecodable word ends the program
    assign stop = dec_i.valid && dec_i.illegal;
    assign run  = (state_q == RUN);

    assign fetch_en_o    = run && !rob_full_i && !stop;
    assign dispatch_en_o = run && !rob_full_i && dec_i.valid && !dec_i.illegal;
    assign halted_o      = (state_q == HALTED);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            RUN:     if (stop) state_d = DRAIN;
            DRAIN:   if (rob_empty_i) state_d = HALTED;
            default: state_d = HALTED;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RUN;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              fetch_en_i,
    input  helios_pkg::insn_t idata_i,
    output helios_pkg::addr_t iaddr_o,
    output helios_pkg::insn_t insn_o,
    output logic              insn_valid_o
);
    import helios_pkg::*;

    addr_t pc_q;

    assign iaddr_o = pc_q;

    // word for the current pc is captured along with the pc step
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q         <= ENTRY_POINT;
            insn_o       <= '0;
            insn_valid_o <= 1'b0;
        end else if (fetch_en_i) begin
            pc_q         <= pc_q + addr_t'(4);
            insn_o       <= idata_i;
            insn_valid_o <= 1'b1;
        end
    end

endmodule

/* src/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      fetch_en_i,
    input  helios_pkg::insn_t         insn_i,
    input  logic                      insn_valid_i,
    output helios_pkg::decoded_insn_t dec_o
);
    import helios_pkg::*;

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic          alt;
    logic          legal;
    decoded_insn_t dec_d;

    assign opcode = insn_i[6:0];
    assign funct3 = insn_i[14:12];
    // funct7 bit 5 picks SUB and SRA
    assign alt    = insn_i[30];
    assign legal  = (opcode == OPC_OP) || (opcode == OPC_OP_IMM);

    always_comb begin
        dec_d         = '0;
        dec_d.valid   = insn_valid_i;
        dec_d.rd      = insn_i[11:7];
        dec_d.rs1     = insn_i[19:15];
        dec_d.rs2     = insn_i[24:20];
        dec_d.imm     = {{20{insn_i[31]}}, insn_i[31:20]};
        dec_d.use_imm = (opcode == OPC_OP_IMM);
        // x0 is never renamed
        dec_d.wr_reg  = legal && (insn_i[11:7] != 5'd0);
        dec_d.illegal = !legal;
        unique case (funct3)
            3'b000:  dec_d.alu_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  dec_d.alu_op = ALU_SLL;
            3'b010:  dec_d.alu_op = ALU_SLT;
            3'b011:  dec_d.alu_op = ALU_SLTU;
            3'b100:  dec_d.alu_op = ALU_XOR;
            3'b101:  dec_d.alu_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  dec_d.alu_op = ALU_OR;
            default: dec_d.alu_op = ALU_AND;
        endcase
    end

    // holds while fetch is stalled
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_o <= '0;
        end else if (fetch_en_i) begin
            dec_o <= dec_d;
        end
    end

endmodule

/* src/rename_unit.sv */
`timescale 1ns/1ps

module rename_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      dispatch_en_i,
    input  helios_pkg::decoded_insn_t dec_i,
    input  helios_pkg::rrf_tag_t      alloc_tag_i,
    input  helios_pkg::exe_result_t   result_i,
    input  helios_pkg::commit_t       commit_i,
    output helios_pkg::dispatch_t     disp_o
);
    import helios_pkg::*;

    data_t              arf_q [32];
    logic [31:0]        busy_q;
    rrf_tag_t           map_q [32];
    data_t              rrf_q [RRF_NUM];
    logic [RRF_NUM-1:0] written_q;
    data_t              src1;
    data_t              src2;

    // zero, then result bus, then rename entry, then arch file
    function automatic data_t read_src(reg_sel_t rs);
        rrf_tag_t tag;
        tag = map_q[rs];
        if (rs == 5'd0) begin
            return '0;
        end else if (busy_q[rs] && result_i.valid && result_i.tag == tag) begin
            return result_i.data;
        end else if (busy_q[rs] && written_q[tag]) begin
            return rrf_q[tag];
        end
        return arf_q[rs];
    endfunction

    always_comb begin
        src1 = read_src(dec_i.rs1);
        src2 = read_src(dec_i.rs2);
    end

    assign disp_o.valid  = dispatch_en_i;
    assign disp_o.tag    = alloc_tag_i;
    assign disp_o.op1    = src1;
    assign disp_o.op2    = dec_i.use_imm ? dec_i.imm : src2;
    assign disp_o.alu_op = dec_i.alu_op;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            arf_q <= '{default: '0};
        end else if (commit_i.valid && commit_i.wr_reg && commit_i.rd != 5'd0) begin
            arf_q[commit_i.rd] <= commit_i.data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
            map_q  <= '{default: '0};
        end else begin
            // a newer mapping keeps the register busy
            if (commit_i.valid && commit_i.wr_reg && map_q[commit_i.rd] == commit_i.tag) begin
                busy_q[commit_i.rd] <= 1'b0;
            end
            if (dispatch_en_i && dec_i.wr_reg) begin
                busy_q[dec_i.rd] <= 1'b1;
                map_q[dec_i.rd]  <= alloc_tag_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (result_i.valid) begin
            rrf_q[result_i.tag] <= result_i.data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            written_q <= '0;
        end else begin
            if (dispatch_en_i) begin
                written_q[alloc_tag_i] <= 1'b0;
            end
            if (result_i.valid) begin
                written_q[result_i.tag] <= 1'b1;
            end
        end
    end

endmodule

/* src/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  helios_pkg::dispatch_t   disp_i,
    output helios_pkg::exe_result_t result_o
);
    import helios_pkg::*;

    dispatch_t  disp_q;
    logic [4:0] shamt;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            disp_q <= '0;
        end else begin
            disp_q <= disp_i;
        end
    end

    assign shamt = disp_q.op2[4:0];

    assign result_o.valid = disp_q.valid;
    assign result_o.tag   = disp_q.tag;

    always_comb begin
        unique case (disp_q.alu_op)
            ALU_ADD:  result_o.data = disp_q.op1 + disp_q.op2;
            ALU_SUB:  result_o.data = disp_q.op1 - disp_q.op2;
            ALU_AND:  result_o.data = disp_q.op1 & disp_q.op2;
            ALU_OR:   result_o.data = disp_q.op1 | disp_q.op2;
            ALU_XOR:  result_o.data = disp_q.op1 ^ disp_q.op2;
            ALU_SLL:  result_o.data = disp_q.op1 << shamt;
            ALU_SRL:  result_o.data = disp_q.op1 >> shamt;
            ALU_SRA:  result_o.data = data_t'($signed(disp_q.op1) >>> shamt);
            ALU_SLT:  result_o.data = data_t'($signed(disp_q.op1) < $signed(disp_q.op2));
            ALU_SLTU: result_o.data = data_t'(disp_q.op1 < disp_q.op2);
            default:  result_o.data = '0;
        endcase
    end

endmodule

/* src/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      dispatch_en_i,
    input  helios_pkg::decoded_insn_t dec_i,
    input  helios_pkg::exe_result_t   result_i,
    output helios_pkg::rrf_tag_t      alloc_tag_o,
    output logic                      rob_full_o,
    output logic                      rob_empty_o,
    output helios_pkg::commit_t       commit_o
);
    import helios_pkg::*;

    rrf_tag_t           head_q;
    rrf_tag_t           tail_q;
    logic [RRF_SEL:0]   count_q;
    logic [RRF_NUM-1:0] finished_q;
    reg_sel_t           rd_q [RRF_NUM];
    logic               wr_reg_q [RRF_NUM];
    data_t              data_q [RRF_NUM];
    logic               do_commit;

    assign alloc_tag_o = tail_q;
    assign rob_full_o  = (count_q == (RRF_SEL + 1)'(RRF_NUM));
    assign rob_empty_o = (count_q == '0);

    // head retires once its result is back
    assign do_commit       = finished_q[head_q];
    assign commit_o.valid  = do_commit;
    assign commit_o.tag    = head_q;
    assign commit_o.rd     = rd_q[head_q];
    assign commit_o.wr_reg = wr_reg_q[head_q];
    assign commit_o.data   = data_q[head_q];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            finished_q <= '0;
        end else begin
            if (dispatch_en_i) begin
                tail_q             <= tail_q + rrf_tag_t'(1);
                finished_q[tail_q] <= 1'b0;
            end
            if (result_i.valid) begin
                finished_q[result_i.tag] <= 1'b1;
            end
            if (do_commit) begin
                head_q             <= head_q + rrf_tag_t'(1);
                finished_q[head_q] <= 1'b0;
            end
            unique case ({dispatch_en_i, do_commit})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (dispatch_en_i) begin
            rd_q[tail_q]     <= dec_i.rd;
            wr_reg_q[tail_q] <= dec_i.wr_reg;
        end
        if (result_i.valid) begin
            data_q[result_i.tag] <= result_i.data;
        end
    end

endmodule

/* src/helios_core.sv */
`timescale 1ns/1ps

module helios_core (
    input  logic                clk_i,
    input  logic                rst_n_i,
    output helios_pkg::addr_t   iaddr_o,
    input  helios_pkg::insn_t   idata_i,
    output helios_pkg::commit_t commit_o,
    output logic                halted_o
);
    import helios_pkg::*;

    insn_t         fetch_insn;
    logic          fetch_valid;
    decoded_insn_t dec;
    dispatch_t     disp;
    exe_result_t   result;
    rrf_tag_t      alloc_tag;
    logic          rob_full;
    logic          rob_empty;
    logic          fetch_en;
    logic          dispatch_en;

    core_ctrl u_core_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .dec_i         (dec),
        .rob_full_i    (rob_full),
        .rob_empty_i   (rob_empty),
        .fetch_en_o    (fetch_en),
        .dispatch_en_o (dispatch_en),
        .halted_o      (halted_o)
    );

    // IF
    fetch_unit u_fetch_unit (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_en_i   (fetch_en),
        .idata_i      (idata_i),
        .iaddr_o      (iaddr_o),
        .insn_o       (fetch_insn),
        .insn_valid_o (fetch_valid)
    );

    // ID
    decode_unit u_decode_unit (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_en_i   (fetch_en),
        .insn_i       (fetch_insn),
        .insn_valid_i (fetch_valid),
        .dec_o        (dec)
    );

    // DP
    rename_unit u_rename_unit (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .dispatch_en_i (dispatch_en),
        .dec_i         (dec),
        .alloc_tag_i   (alloc_tag),
        .result_i      (result),
        .commit_i      (commit_o),
        .disp_o        (disp)
    );

    // EX
    alu_unit u_alu_unit (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .disp_i   (disp),
        .result_o (result)
    );

    // COM
    reorder_buffer u_reorder_buffer (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .dispatch_en_i (dispatch_en),
        .dec_i         (dec),
        .result_i      (result),
        .alloc_tag_o   (alloc_tag),
        .rob_full_o    (rob_full),
        .rob_empty_o   (rob_empty),
        .commit_o      (commit_o)
    );

endmodule

/* verif/helios_core_asserts.sv */
`timescale 1ns/1ps

module helios_core_asserts (
    input logic                clk_i,
    input logic                rst_n_i,
    input helios_pkg::addr_t   iaddr_o,
    input helios_pkg::commit_t commit_o,
    input logic                halted_o
);

    // running count of failed properties
    int unsigned fail_count = 0;

    // nothing retires while held in reset
    commit_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !commit_o.valid)
        else begin
            fail_count++;
            $error("commit seen while reset is asserted");
        end

    halt_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        halted_o |=> halted_o)
        else begin
            fail_count++;
            $error("halt flag dropped without a reset");
        end

    // fetch frozen once halted
    pc_frozen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        halted_o |=> $stable(iaddr_o))
        else begin
            fail_count++;
            $error("fetch address moved after halt");
        end

    commit_rd_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        commit_o.valid |-> !$isunknown(commit_o.rd))
        else begin
            fail_count++;
            $error("commit carries an unknown destination register");
        end

endmodule

/* verif/tb_helios_core.sv */
`timescale 1ns/1ps

module tb_helios_core;
    import helios_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RAND_LEN   = 300;
    localparam int NUM_TESTS  = 6;
    // hand-written programs hold 12, 10, 6 and 4 instructions
    localparam int PROG_INSNS = 12 + 10 + 6 + 4 + RAND_LEN;

    logic        clk_i = 1'b0;
    logic        rst_n_i = 1'b0;
    addr_t       iaddr;
    insn_t       idata;
    commit_t     commit;
    logic        halted;

    insn_t       imem [1024];
    int          prog_len;
    commit_t     expect_q [$];
    commit_t     exp_c;
    addr_t       held_addr;
    string       test_name = "reset";
    int          test_errs = 0;
    int          n_commits = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int unsigned bound_seen = 0;
    integer      seed = 32'h8a34;

    helios_core dut_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .iaddr_o  (iaddr),
        .idata_i  (idata),
        .commit_o (commit),
        .halted_o (halted)
    );

    bind helios_core helios_core_asserts u_asserts (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .iaddr_o  (iaddr_o),
        .commit_o (commit_o),
        .halted_o (halted_o)
    );

    // combinational instruction memory, zero past the program
    assign idata = (iaddr < 32'd4096) ? imem[iaddr[11:2]] : '0;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic insn_t op_rr(logic [2:0] f3, logic alt, reg_sel_t rd, reg_sel_t rs1,
                                    reg_sel_t rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic insn_t op_ri(logic [2:0] f3, reg_sel_t rd, reg_sel_t rs1,
                                    logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    task automatic append_insn(insn_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic clear_program();
        foreach (imem[i]) begin
            imem[i] = '0;
        end
        prog_len = 0;
    endtask

    // low registers only, so dependencies come up often
    function automatic insn_t random_insn();
        logic [31:0] r;
        logic [11:0] imm;
        logic [2:0]  f3;
        r   = $random(seed);
        imm = 12'($random(seed));
        f3  = r[14:12];
        if (r[16]) begin
            return op_rr(f3, r[15] && (f3 == 3'b000 || f3 == 3'b101), {1'b0, r[3:0]},
                         {1'b0, r[7:4]}, {1'b0, r[11:8]});
        end
        if (f3 == 3'b001) begin
            imm = {7'b0, imm[4:0]};
        end else if (f3 == 3'b101) begin
            imm = {1'b0, r[15], 5'b0, imm[4:0]};
        end
        return op_ri(f3, {1'b0, r[3:0]}, {1'b0, r[7:4]}, imm);
    endfunction

    // RV32I ALU semantics, b is rs2 or the sign-extended immediate
    function automatic data_t alu_ref(insn_t w, data_t a, data_t b);
        logic  alt;
        data_t r;
        alt = w[30] && (w[6:0] == OPC_OP || w[14:12] == 3'b101);
        case (w[14:12])
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = {31'b0, $signed(a) < $signed(b)};
            3'b011:  r = {31'b0, a < b};
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic void build_expected();
        data_t   regs [32];
        insn_t   w;
        data_t   b;
        commit_t c;
        regs = '{default: '0};
        expect_q.delete();
        for (int i = 0; i < prog_len; i++) begin
            w = imem[i];
            b = (w[6:0] == OPC_OP) ? regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
            c = '0;
            c.valid  = 1'b1;
            // rob slots are handed out in order from zero after reset
            c.tag    = rrf_tag_t'(i);
            c.rd     = w[11:7];
            c.wr_reg = (w[11:7] != 5'd0);
            c.data   = alu_ref(w, regs[w[19:15]], b);
            if (c.wr_reg) begin
                regs[c.rd] = c.data;
            end
            expect_q.push_back(c);
        end
    endfunction

    always @(negedge clk_i) begin
        if (rst_n_i && commit.valid) begin
            n_commits++;
            assert (expect_q.size() != 0) else begin
                $display("%s: a commit to x%0d came after the whole program had retired",
                         test_name, commit.rd);
                test_errs++;
            end
            if (expect_q.size() != 0) begin
                exp_c = expect_q.pop_front();
                assert (commit.tag == exp_c.tag && commit.rd == exp_c.rd &&
                        commit.wr_reg == exp_c.wr_reg && commit.data == exp_c.data) else begin
                    $write("[FAIL] %s: expected tag=%0d rd=x%0d wr=%0b data=%h, ",
                           test_name, exp_c.tag, exp_c.rd, exp_c.wr_reg, exp_c.data);
                    $display("actual tag=%0d rd=x%0d wr=%0b data=%h",
                             commit.tag, commit.rd, commit.wr_reg, commit.data);
                    test_errs++;
                end
            end
        end
    end

    task automatic apply_reset();
        rst_n_i = 1'b0;
        repeat (16) @(negedge clk_i);
        rst_n_i = 1'b1;
    endtask

    task automatic check_reset_state(string when);
        assert (iaddr == ENTRY_POINT && !commit.valid && !halted) else begin
            $display("[FAIL] reset %s: expected iaddr=%h valid=0 halted=0, actual iaddr=%h valid=%0b halted=%0b",
                     when, ENTRY_POINT, iaddr, commit.valid, halted);
            test_errs++;
        end
    endtask

    task automatic run_program(string name);
        test_name = name;
        test_errs = 0;
        n_commits = 0;
        build_expected();
        apply_reset();
        while (!halted) @(negedge clk_i);
        @(negedge clk_i);
        assert (n_commits == prog_len) else begin
            $display("[FAIL] %s: expected %0d commits, actual %0d", name, prog_len, n_commits);
            test_errs++;
        end
    endtask

    task automatic report_test();
        int unsigned bound_errs;
        bound_errs = dut_i.u_asserts.fail_count - bound_seen;
        bound_seen = dut_i.u_asserts.fail_count;
        if (test_errs == 0 && bound_errs == 0) begin
            n_pass++;
            $display("[PASS] %s", test_name);
        end else begin
            n_fail++;
            $display("[FAIL] %s with %0d errors", test_name, test_errs + bound_errs);
        end
    endtask

    initial begin
        clear_program();
        repeat (8) @(negedge clk_i);
        check_reset_state("during");
        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;
        check_reset_state("release");
        // empty memory halts at once
        while (!halted) @(negedge clk_i);
        report_test();

        clear_program();
        append_insn(op_ri(3'b000, 5'd1, 5'd0, 12'd123));
        append_insn(op_ri(3'b000, 5'd2, 5'd0, 12'hfd3));
        append_insn(op_ri(3'b110, 5'd4, 5'd0, 12'h3f0));
        append_insn(op_ri(3'b000, 5'd5, 5'd0, 12'd3));
        append_insn(op_ri(3'b011, 5'd3, 5'd2, 12'hfff));
        append_insn(op_rr(3'b000, 1'b1, 5'd6, 5'd1, 5'd2));
        append_insn(op_rr(3'b111, 1'b0, 5'd7, 5'd1, 5'd4));
        append_insn(op_rr(3'b001, 1'b0, 5'd10, 5'd1, 5'd5));
        append_insn(op_rr(3'b101, 1'b1, 5'd11, 5'd2, 5'd5));
        append_insn(op_rr(3'b101, 1'b0, 5'd12, 5'd2, 5'd5));
        append_insn(op_rr(3'b011, 1'b0, 5'd13, 5'd1, 5'd2));
        append_insn(op_rr(3'b010, 1'b0, 5'd14, 5'd2, 5'd1));
        run_program("independent");
        report_test();

        clear_program();
        append_insn(op_ri(3'b000, 5'd1, 5'd0, 12'hc18));
        append_insn(op_ri(3'b000, 5'd2, 5'd1, 12'd7));
        append_insn(op_rr(3'b000, 1'b1, 5'd3, 5'd2, 5'd1));
        append_insn(op_rr(3'b001, 1'b0, 5'd4, 5'd3, 5'd3));
        append_insn(op_ri(3'b101, 5'd5, 5'd4, 12'h402));
        append_insn(op_rr(3'b100, 1'b0, 5'd6, 5'd5, 5'd4));
        append_insn(op_rr(3'b010, 1'b0, 5'd7, 5'd6, 5'd5));
        append_insn(op_rr(3'b000, 1'b0, 5'd8, 5'd7, 5'd6));
        append_insn(op_ri(3'b101, 5'd9, 5'd8, 12'h001));
        append_insn(op_ri(3'b111, 5'd10, 5'd9, 12'h0ff));
        run_program("dependent chain");
        report_test();

        clear_program();
        append_insn(op_ri(3'b000, 5'd0, 5'd0, 12'd55));
        append_insn(op_rr(3'b000, 1'b0, 5'd1, 5'd0, 5'd0));
        append_insn(op_ri(3'b000, 5'd0, 5'd1, 12'd9));
        append_insn(op_ri(3'b110, 5'd2, 5'd0, 12'd3));
        append_insn(op_rr(3'b000, 1'b1, 5'd3, 5'd0, 5'd2));
        append_insn(op_ri(3'b100, 5'd4, 5'd0, 12'hfff));
        run_program("register x0");
        report_test();

        clear_program();
        repeat (RAND_LEN) append_insn(random_insn());
        run_program("random program");
        report_test();

        clear_program();
        append_insn(op_ri(3'b000, 5'd1, 5'd0, 12'd1));
        append_insn(op_ri(3'b001, 5'd2, 5'd1, 12'h00c));
        append_insn(op_rr(3'b110, 1'b0, 5'd3, 5'd2, 5'd1));
        append_insn(op_rr(3'b011, 1'b0, 5'd4, 5'd0, 5'd3));
        run_program("halt");
        held_addr = iaddr;
        repeat (20) @(negedge clk_i);
        assert (halted && iaddr == held_addr) else begin
            $display("[FAIL] halt: expected iaddr=%h halted=1, actual iaddr=%h halted=%0b",
                     held_addr, iaddr, halted);
            test_errs++;
        end
        report_test();

        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((20 * PROG_INSNS + 200 * NUM_TESTS) * CLK_PERIOD);
        $display("timeout: the core never halted during test %s", test_name);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* tb.f */
src/helios_pkg.sv
src/core_ctrl.sv
src/fetch_unit.sv
src/decode_unit.sv
src/rename_unit.sv
src/alu_unit.sv
src/reorder_buffer.sv
src/helios_core.sv
verif/helios_core_asserts.sv
verif/tb_helios_core.sv

/* Bender.yml */
package:
  name: helios_core

sources:
  - src/helios_pkg.sv
  - src/core_ctrl.sv
  - src/fetch_unit.sv
  - src/decode_unit.sv
  - src/rename_unit.sv
  - src/alu_unit.sv
  - src/reorder_buffer.sv
  - src/helios_core.sv
  - target: test
    files:
      - verif/helios_core_asserts.sv
      - verif/tb_helios_core.sv
